//--- dv/cobs_cases.txt
// listed frame: 1 err n_in in_bytes n_exp expected_bytes
// random frame: 2 err length, list ends with 0, all values hex
1 0 4 11 22 00 33 6 03 11 22 02 33 00
1 0 3 00 11 22 5 01 03 11 22 00
1 0 3 11 22 00 5 03 11 22 01 00
1 0 2 00 00 4 01 01 01 00
1 0 4 11 00 00 22 6 02 11 01 02 22 00
1 0 1 00 3 01 01 00
1 0 1 5a 3 02 5a 00
1 0 5 01 02 03 04 05 7 06 01 02 03 04 05 00
1 0 5 ff 80 01 00 fe 7 04 ff 80 01 02 fe 00
1 1 3 11 22 33 5 03 11 22 02 00
1 1 1 7f 3 01 02 00
1 1 3 11 00 44 5 02 11 01 02 00
1 1 2 00 00 4 01 01 02 00
1 1 3 aa bb 00 5 03 aa bb 02 00
2 0 fd
2 0 fe
2 0 ff
2 0 258
2 1 ff
2 1 12c
2 0 1
1 0 2 33 00 4 02 33 01 00
0

//--- tb.f
+incdir+design
design/cobs_stream_pkg.sv
design/cobs_code_pkg.sv
design/cobs_segment_scan.sv
design/cobs_byte_fifo.sv
design/cobs_frame_merge.sv
design/cobs_encoder_top.sv
dv/cobs_check.sv
dv/cobs_encoder_sva.sv
dv/tb_cobs_encoder.sv

//--- dv/tb_cobs_encoder.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cobs_encoder
    import cobs_stream_pkg::*;
();

    logic         clk;
    logic         rst;
    stream_beat_t in_beat;
    logic         in_valid;
    logic         in_ready;
    stream_beat_t out_beat;
    logic         out_valid;
    logic         out_ready;

    // case file words with the columns given at the top of the file
    logic [15:0]  case_mem [0:1023];
    int           cycle_limit = 0;
    int           cycles = 0;
    int           frame_count = 0;

    cobs_encoder_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    cobs_check check_i (
        .clk       (clk),
        .rst       (rst),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    bind cobs_encoder_top cobs_encoder_sva sva_i (
        .clk       (clk),
        .rst       (rst),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    always #20 clk = ~clk;

    // sink stalls about three cycles in ten
    always @(posedge clk) begin
        #1;
        out_ready <= ($urandom_range(99, 0) < 70);
    end

    task automatic print_counts();
        $display("errors: %0d mismatched, %0d missing, %0d extra, %0d assertion failures",
                 check_i.mismatch_count, check_i.pending(), check_i.extra_count,
                 dut_i.sva_i.fail_count);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            print_counts();
            $display("*** FAILED ***");
            $finish;
        end
    end

    // input plus expected bytes of all cases with runs estimated from their length
    function automatic int count_case_bytes();
        int pos;
        int total;
        int n_in;
        int len;
        pos   = 0;
        total = 0;
        while (case_mem[pos] == 16'h1 || case_mem[pos] == 16'h2) begin
            if (case_mem[pos] == 16'h1) begin
                n_in  = case_mem[pos+2];
                total = total + n_in + case_mem[pos+3+n_in];
                pos   = pos + 4 + n_in + case_mem[pos+3+n_in];
            end else begin
                len   = case_mem[pos+2];
                total = total + 2 * len + len / 254 + 4;
                pos   = pos + 3;
            end
        end
        return total;
    endfunction

    // called 1 ns after an edge and returns 1 ns after the edge that took the byte
    task automatic send_byte(input byte_t data, input logic last, input logic user);
        in_beat.data = data;
        in_beat.last = last;
        in_beat.user = user;
        in_valid     = 1'b1;
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
        #1;
        in_valid = 1'b0;
        in_beat  = '0;
        if ($urandom_range(7, 0) == 0) begin
            repeat ($urandom_range(4, 1)) @(posedge clk);
            #1;
        end
    endtask

    task automatic play_listed_frame(inout int pos);
        logic err;
        int   n_in;
        int   n_exp;
        int   base;
        err   = case_mem[pos+1][0];
        n_in  = case_mem[pos+2];
        base  = pos + 3;
        n_exp = case_mem[base+n_in];
        for (int i = 0; i < n_exp; i++) begin
            check_i.push_expected(case_mem[base+n_in+1+i][7:0], i == n_exp - 1,
                                  err && (i == n_exp - 1));
        end
        for (int i = 0; i < n_in; i++) begin
            send_byte(case_mem[base+i][7:0], i == n_in - 1, err && (i == n_in - 1));
        end
        pos = base + n_in + 1 + n_exp;
    endtask

    task automatic play_random_frame(inout int pos);
        logic  err;
        int    len;
        byte_t frame[$];
        err = case_mem[pos+1][0];
        len = case_mem[pos+2];
        for (int i = 0; i < len; i++) begin
            frame.push_back(byte_t'($urandom_range(255, 1)));
            check_i.model_add(frame[i]);
        end
        check_i.model_close(err);
        foreach (frame[i]) begin
            send_byte(frame[i], i == len - 1, err && (i == len - 1));
        end
        pos = pos + 3;
    endtask

    initial begin
        int pos;
        clk       = 1'b0;
        rst       = 1'b1;
        in_beat   = '0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        void'($urandom(32'h7f5e));
        $readmemh("dv/cobs_cases.txt", case_mem);
        cycle_limit = 8 * count_case_bytes() + 500;

        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        pos = 0;
        while (case_mem[pos] == 16'h1 || case_mem[pos] == 16'h2) begin
            if (case_mem[pos] == 16'h1) begin
                play_listed_frame(pos);
            end else begin
                play_random_frame(pos);
            end
            frame_count++;
        end
        if (frame_count == 0) begin
            $display("no frames were read from dv/cobs_cases.txt");
        end

        // drain and then give stray beats time to show up
        while (check_i.pending() != 0) begin
            @(posedge clk);
        end
        repeat (40) @(posedge clk);

        print_counts();
        if (check_i.error_total() == 0 && dut_i.sva_i.fail_count == 0
            && frame_count != 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/cobs_encoder_sva.sv
`timescale 1ns/10ps
`default_nettype none

module cobs_encoder_sva
    import cobs_stream_pkg::*;
(
    input wire          clk,
    input wire          rst,
    input stream_beat_t out_beat,
    input wire          out_valid,
    input wire          out_ready
);

    // number of assertion failures so far
    int fail_count = 0;

    // output stays idle in reset and in the first cycle out of it
    idle_after_reset: assert property (
        @(posedge clk) $past(rst) |-> !out_valid
    ) else begin
        $error("out_valid is high during reset or in the cycle after it");
        fail_count++;
    end

    // a stalled beat must not move or vanish
    hold_while_stalled: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_beat)
    ) else begin
        $error("out_beat changed while out_valid was high and out_ready low");
        fail_count++;
    end

    // only the frame delimiter closes a frame
    last_on_delimiter: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && out_beat.last |-> out_beat.data == 8'h00
    ) else begin
        $error("out_beat.last is set on a nonzero byte");
        fail_count++;
    end

endmodule

`default_nettype wire

//--- dv/cobs_check.sv
`timescale 1ns/10ps
`default_nettype none

module cobs_check
    import cobs_stream_pkg::*;
(
    input wire          clk,
    input wire          rst,
    input stream_beat_t out_beat,
    input wire          out_valid,
    input wire          out_ready
);

    // longest run that one code byte covers
    localparam int run_limit = 254;

    stream_beat_t exp_q[$];
    byte_t        model_in[$];
    byte_t        run_buf[$];
    int           mismatch_count = 0;
    int           extra_count = 0;
    int           beat_count = 0;

    task automatic push_expected(input byte_t data, input logic last, input logic user);
        stream_beat_t beat;
        beat.data = data;
        beat.last = last;
        beat.user = user;
        exp_q.push_back(beat);
    endtask

    task automatic model_add(input byte_t data);
        model_in.push_back(data);
    endtask

    // code byte first, then the run itself
    task automatic flush_run();
        push_expected(byte_t'(run_buf.size() + 1), 1'b0, 1'b0);
        foreach (run_buf[i]) begin
            push_expected(run_buf[i], 1'b0, 1'b0);
        end
        run_buf.delete();
    endtask

    // reference encoder for one frame held in model_in
    task automatic model_close(input logic err);
        int stop;
        stop = err ? model_in.size() - 1 : model_in.size();
        run_buf.delete();
        for (int i = 0; i < stop; i++) begin
            if (model_in[i] == 8'h00) begin
                flush_run();
            end else begin
                run_buf.push_back(model_in[i]);
                if (run_buf.size() == run_limit) begin
                    flush_run();
                end
            end
        end
        if (err) begin
            // bad frame: close the open run, then the error marker
            flush_run();
            push_expected(8'h02, 1'b0, 1'b0);
        end else if (model_in[stop-1] == 8'h00) begin
            push_expected(8'h01, 1'b0, 1'b0);
        end else if (run_buf.size() != 0) begin
            flush_run();
        end
        push_expected(8'h00, 1'b1, err);
        model_in.delete();
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    function automatic int error_total();
        return mismatch_count + extra_count + exp_q.size();
    endfunction

    task automatic compare_field(input string name, input logic [7:0] want,
                                 input logic [7:0] got);
        if (got !== want) begin
            mismatch_count++;
            $display("error: %s expected %h got %h (output beat %0d)",
                     name, want, got, beat_count);
        end
    endtask

    always @(posedge clk) begin : compare_beats
        stream_beat_t want;
        if (!rst && out_valid && out_ready) begin
            beat_count++;
            if (exp_q.size() == 0) begin
                extra_count++;
                $display("output beat %0d arrived when no more bytes were expected",
                         beat_count);
            end else begin
                want = exp_q.pop_front();
                compare_field("out_beat.data", want.data, out_beat.data);
                compare_field("out_beat.last", 8'(want.last), 8'(out_beat.last));
                compare_field("out_beat.user", 8'(want.user), 8'(out_beat.user));
            end
        end
    end

endmodule

`default_nettype wire

//--- design/cobs_encoder_top.sv
`timescale 1ns/10ps
`default_nettype none

module cobs_encoder_top
    import cobs_stream_pkg::*, cobs_code_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  stream_beat_t in_beat,
    input  wire          in_valid,
    output logic         in_ready,
    output stream_beat_t out_beat,
    output logic         out_valid,
    input  wire          out_ready
);

    code_entry_t code_wr_entry;
    logic        code_wr_valid;
    logic        code_wr_ready;
    code_entry_t code_rd_entry;
    logic        code_rd_valid;
    logic        code_rd_ready;

    byte_t       data_wr_byte;
    logic        data_wr_valid;
    logic        data_wr_ready;
    byte_t       data_rd_byte;
    logic        data_rd_valid;
    logic        data_rd_ready;

    cobs_segment_scan scan_i (
        .clk           (clk),
        .rst           (rst),
        .in_beat       (in_beat),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .code_wr_entry (code_wr_entry),
        .code_wr_valid (code_wr_valid),
        .code_wr_ready (code_wr_ready),
        .data_wr_byte  (data_wr_byte),
        .data_wr_valid (data_wr_valid),
        .data_wr_ready (data_wr_ready)
    );

    // code bytes with their last and user flags
    cobs_byte_fifo #(
        .WIDTH ($bits(code_entry_t))
    ) code_fifo_i (
        .clk      (clk),
        .rst      (rst),
        .wr_entry (code_wr_entry),
        .wr_valid (code_wr_valid),
        .wr_ready (code_wr_ready),
        .rd_entry (code_rd_entry),
        .rd_valid (code_rd_valid),
        .rd_ready (code_rd_ready)
    );

    cobs_byte_fifo #(
        .WIDTH ($bits(byte_t))
    ) data_fifo_i (
        .clk      (clk),
        .rst      (rst),
        .wr_entry (data_wr_byte),
        .wr_valid (data_wr_valid),
        .wr_ready (data_wr_ready),
        .rd_entry (data_rd_byte),
        .rd_valid (data_rd_valid),
        .rd_ready (data_rd_ready)
    );

    cobs_frame_merge merge_i (
        .clk           (clk),
        .rst           (rst),
        .code_rd_entry (code_rd_entry),
        .code_rd_valid (code_rd_valid),
        .code_rd_ready (code_rd_ready),
        .data_rd_byte  (data_rd_byte),
        .data_rd_valid (data_rd_valid),
        .data_rd_ready (data_rd_ready),
        .out_beat      (out_beat),
        .out_valid     (out_valid),
        .out_ready     (out_ready)
    );

endmodule

`default_nettype wire

//--- design/cobs_frame_merge.sv
`timescale 1ns/10ps
`default_nettype none

`include "cobs_macros.svh"

module cobs_frame_merge
    import cobs_stream_pkg::*, cobs_code_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  code_entry_t  code_rd_entry,
    input  wire          code_rd_valid,
    output logic         code_rd_ready,
    input  byte_t        data_rd_byte,
    input  wire          data_rd_valid,
    output logic         data_rd_ready,
    output stream_beat_t out_beat,
    output logic         out_valid,
    input  wire          out_ready
);

    merge_state_e state;
    merge_state_e state_next;
    run_count_t   remain;
    run_count_t   remain_next;

    // beat offered by the merge FSM to the output stage
    stream_beat_t int_beat;
    logic         int_valid;
    logic         int_ready;
    logic         int_ready_early;

    stream_beat_t skid_beat;
    logic         skid_valid;
    logic         skid_valid_next;
    logic         out_valid_next;
    logic         store_int_to_out;
    logic         store_int_to_skid;
    logic         store_skid_to_out;

    logic         code_take;
    logic         data_take;

    assign code_rd_ready = int_ready && (state == code);
    assign data_rd_ready = int_ready && (state == run);
    assign code_take     = code_rd_ready && code_rd_valid;
    assign data_take     = data_rd_ready && data_rd_valid;

    always_comb begin
        state_next  = state;
        remain_next = remain;
        int_beat    = '0;
        int_valid   = 1'b0;

        case (state)
            code: begin
                if (code_take) begin
                    int_beat.data = byte_t'(code_rd_entry.code);
                    int_beat.last = code_rd_entry.last;
                    // only the delimiter reports a bad frame downstream
                    int_beat.user = code_rd_entry.user && code_rd_entry.last;
                    int_valid     = 1'b1;
                    remain_next   = run_count_t'(code_rd_entry.code - 8'd1);
                    // delimiter, empty run and error marker carry no data
                    if (!(code_rd_entry.code == code_t'(`COBS_DELIM)
                          || code_rd_entry.code == code_t'(`COBS_CODE_ZERO)
                          || code_rd_entry.user)) begin
                        state_next = run;
                    end
                end
            end

            run: begin
                if (data_take) begin
                    int_beat.data = data_rd_byte;
                    int_valid     = 1'b1;
                    remain_next   = remain - 8'd1;
                    if (remain == 8'd1) begin
                        state_next = code;
                    end
                end
            end

            default: begin
                state_next = code;
            end
        endcase
    end

    // next cycle can accept a beat if the output drains or the skid stays empty
    assign int_ready_early = out_ready || (!skid_valid && (!out_valid || !int_valid));

    always_comb begin
        out_valid_next    = out_valid;
        skid_valid_next   = skid_valid;
        store_int_to_out  = 1'b0;
        store_int_to_skid = 1'b0;
        store_skid_to_out = 1'b0;

        if (int_ready) begin
            if (out_ready || !out_valid) begin
                out_valid_next   = int_valid;
                store_int_to_out = 1'b1;
            end else begin
                // output stalled, park the beat
                skid_valid_next   = int_valid;
                store_int_to_skid = 1'b1;
            end
        end else if (out_ready) begin
            out_valid_next    = skid_valid;
            skid_valid_next   = 1'b0;
            store_skid_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= code;
            remain     <= '0;
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
            int_ready  <= 1'b0;
        end else begin
            state      <= state_next;
            remain     <= remain_next;
            out_valid  <= out_valid_next;
            skid_valid <= skid_valid_next;
            int_ready  <= int_ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (store_int_to_out) begin
            out_beat <= int_beat;
        end else if (store_skid_to_out) begin
            out_beat <= skid_beat;
        end

        if (store_int_to_skid) begin
            skid_beat <= int_beat;
        end
    end

endmodule

`default_nettype wire

//--- design/cobs_byte_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "cobs_macros.svh"

module cobs_byte_fifo #(
    parameter int WIDTH = 8
) (
    input  wire              clk,
    input  wire              rst,
    input  wire [WIDTH-1:0]  wr_entry,
    input  wire              wr_valid,
    output logic             wr_ready,
    output logic [WIDTH-1:0] rd_entry,
    output logic             rd_valid,
    input  wire              rd_ready
);

    localparam int AW    = `COBS_FIFO_AW;
    localparam int DEPTH = 1 << AW;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      fill;
    logic [AW:0]      fill_next;
    logic             wr_fire;
    logic             rd_fire;

    assign wr_fire = wr_valid && wr_ready;
    assign rd_fire = rd_valid && rd_ready;

    // head entry is shown without waiting for a read
    assign rd_valid = (fill != '0);
    assign rd_entry = mem[rd_ptr];

    always_comb begin
        fill_next = fill;
        case ({wr_fire, rd_fire})
            2'b10:   fill_next = fill + 1'b1;
            2'b01:   fill_next = fill - 1'b1;
            default: fill_next = fill;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill     <= '0;
            wr_ready <= 1'b0;
        end else begin
            wr_ptr   <= wr_ptr + AW'(wr_fire);
            rd_ptr   <= rd_ptr + AW'(rd_fire);
            fill     <= fill_next;
            // at most one write per cycle, so looking one fill ahead is enough
            wr_ready <= (fill_next != (AW+1)'(DEPTH));
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= wr_entry;
        end
    end

endmodule

`default_nettype wire

//--- design/cobs_segment_scan.sv
`timescale 1ns/10ps
`default_nettype none

`include "cobs_macros.svh"

module cobs_segment_scan
    import cobs_stream_pkg::*, cobs_code_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  stream_beat_t in_beat,
    input  wire          in_valid,
    output logic         in_ready,
    output code_entry_t  code_wr_entry,
    output logic         code_wr_valid,
    input  wire          code_wr_ready,
    output byte_t        data_wr_byte,
    output logic         data_wr_valid,
    input  wire          data_wr_ready
);

    // closing code of a frame that ended with an error
    localparam code_t err_code = code_t'(`COBS_CODE_ZERO + 1);

    scan_state_e state;
    scan_state_e state_next;
    run_count_t  run_len;
    run_count_t  run_len_next;
    logic        fail;
    logic        fail_next;

    run_count_t  cur_len;
    run_count_t  grown_len;
    logic        in_open;
    logic        take;
    logic        close_run;

    // nonzero bytes pass to the data queue as they are
    assign data_wr_byte = in_beat.data;

    // idle means no byte of the current run has been seen yet
    assign cur_len   = (state == segment) ? run_len : '0;
    assign grown_len = cur_len + 8'd1;

    // both queues need room since one input byte may write to each
    assign in_open  = (state == idle) || (state == segment);
    assign in_ready = in_open && code_wr_ready && data_wr_ready;
    assign take     = in_ready && in_valid;

    // a zero, or a bad last byte, closes the run and stores no data
    assign close_run = (in_beat.data == byte_t'(`COBS_DELIM))
                    || (in_beat.last && in_beat.user);

    always_comb begin
        state_next    = state;
        run_len_next  = run_len;
        fail_next     = fail;
        code_wr_entry = '0;
        code_wr_valid = 1'b0;
        data_wr_valid = 1'b0;

        case (state)
            idle, segment: begin
                if (take) begin
                    if (close_run) begin
                        // code is run length plus one
                        code_wr_entry.code = code_t'(grown_len);
                        code_wr_valid      = 1'b1;
                        run_len_next       = '0;
                        if (in_beat.last) begin
                            fail_next  = in_beat.user;
                            state_next = final_zero;
                        end else begin
                            state_next = idle;
                        end
                    end else begin
                        data_wr_valid = 1'b1;
                        run_len_next  = grown_len;
                        state_next    = segment;
                        // full run or frame end, emit the code right away
                        if (grown_len == run_count_t'(`COBS_MAX_RUN) || in_beat.last) begin
                            code_wr_entry.code = code_t'(grown_len + 8'd1);
                            code_wr_valid      = 1'b1;
                            run_len_next       = '0;
                        end
                        if (in_beat.last) begin
                            state_next = delimiter;
                        end
                    end
                end
            end

            final_zero: begin
                // trailing empty run, or the error marker
                code_wr_entry.code = fail ? err_code : code_t'(`COBS_CODE_ZERO);
                code_wr_entry.user = fail;
                code_wr_valid      = 1'b1;
                if (code_wr_ready) begin
                    state_next = delimiter;
                end
            end

            delimiter: begin
                code_wr_entry.code = code_t'(`COBS_DELIM);
                code_wr_entry.last = 1'b1;
                code_wr_entry.user = fail;
                code_wr_valid      = 1'b1;
                if (code_wr_ready) begin
                    fail_next  = 1'b0;
                    state_next = idle;
                end
            end

            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= idle;
            run_len <= '0;
            fail    <= 1'b0;
        end else begin
            state   <= state_next;
            run_len <= run_len_next;
            fail    <= fail_next;
        end
    end

endmodule

`default_nettype wire

//--- design/cobs_code_pkg.sv
`default_nettype none

package cobs_code_pkg;

    import cobs_stream_pkg::*;

    // code bytes go out on the same byte lane as data
    typedef logic [$bits(byte_t)-1:0] code_t;

    // number of nonzero bytes seen or still to send in a run
    typedef logic [7:0] run_count_t;

    // one code queue entry, the delimiter entry carries last
    typedef struct packed {
        code_t code;
        logic  last;
        logic  user;
    } code_entry_t;

    // input scanner
    typedef enum logic [1:0] {
        idle,
        segment,
        final_zero,
        delimiter
    } scan_state_e;

    // output merge
    typedef enum logic {
        code,
        run
    } merge_state_e;

endpackage

`default_nettype wire

//--- design/cobs_stream_pkg.sv
`default_nettype none

package cobs_stream_pkg;

    // one byte on the input or output stream
    typedef logic [7:0] byte_t;

    // payload of one stream beat
    // last closes a frame, user marks a frame as bad
    typedef struct packed {
        byte_t data;
        logic  last;
        logic  user;
    } stream_beat_t;

endpackage

`default_nettype wire

//--- design/cobs_macros.svh
`ifndef COBS_MACROS_SVH
`define COBS_MACROS_SVH

// longest run of nonzero bytes that one code byte can cover
`define COBS_MAX_RUN 254

// queue depth is 2**COBS_FIFO_AW entries
`define COBS_FIFO_AW 8

// code byte of a run with no data bytes
`define COBS_CODE_ZERO 1

// in-band frame delimiter, also the byte value that gets stuffed away
`define COBS_DELIM 0

`endif
